// ==== verilog/decode_pkg.sv ====
package decode_pkg;

   ////////////////////
   // Vector types
   ////////////////////

   typedef logic [31:0] word_t;
   typedef logic [4:0]  reg_addr_t;
   typedef logic [5:0]  opcode_t;
   typedef logic [5:0]  func_t;
   typedef logic [15:0] imm_t;
   typedef logic [4:0]  shamt_t;
   typedef logic [25:0] jump_addr_t;
   typedef logic [3:0]  alu_op_t;
   typedef logic [1:0]  mem_size_t;

   localparam int unsigned NUM_REGS = 32;

   // Field positions inside the instruction word
   localparam int unsigned MSB_OPCODE = 31;
   localparam int unsigned MSB_RS     = 25;
   localparam int unsigned MSB_RT     = 20;
   localparam int unsigned MSB_RD     = 15;
   localparam int unsigned MSB_SHAMT  = 10;
   localparam int unsigned MSB_FUNC   = 5;
   localparam int unsigned MSB_IMM    = 15;
   localparam int unsigned MSB_JUMP   = 25;

   localparam reg_addr_t LINK_REG_ADDR = 5'd31;

   localparam mem_size_t SIZE_BYTE = 2'd0;
   localparam mem_size_t SIZE_HALF = 2'd1;
   localparam mem_size_t SIZE_WORD = 2'd2;

   ////////////////////
   // Opcodes
   ////////////////////

   localparam opcode_t R_INST = 6'b0000_00;
   localparam opcode_t LB     = 6'b1000_00;
   localparam opcode_t LH     = 6'b1000_01;
   localparam opcode_t LW     = 6'b1000_11;
   localparam opcode_t LBU    = 6'b1001_00;
   localparam opcode_t LHU    = 6'b1001_01;
   localparam opcode_t LWU    = 6'b1001_11;
   localparam opcode_t SB     = 6'b1010_00;
   localparam opcode_t SH     = 6'b1010_01;
   localparam opcode_t SW     = 6'b1010_11;
   localparam opcode_t ADDI   = 6'b0010_01;
   localparam opcode_t ANDI   = 6'b0011_00;
   localparam opcode_t ORI    = 6'b0011_01;
   localparam opcode_t XORI   = 6'b0011_10;
   localparam opcode_t LUI    = 6'b0011_11;
   localparam opcode_t SLTI   = 6'b0010_10;
   localparam opcode_t BEQ    = 6'b0001_00;
   localparam opcode_t BNE    = 6'b0001_01;
   localparam opcode_t J      = 6'b0000_10;
   localparam opcode_t JAL    = 6'b0000_11;

   // R-type function codes
   localparam func_t FUNC_SLL  = 6'b00_0000;
   localparam func_t FUNC_SRL  = 6'b00_0010;
   localparam func_t FUNC_SRA  = 6'b00_0011;
   localparam func_t FUNC_SLLV = 6'b00_0100;
   localparam func_t FUNC_SRLV = 6'b00_0110;
   localparam func_t FUNC_SRAV = 6'b00_0111;
   localparam func_t FUNC_ADDU = 6'b10_0001;
   localparam func_t FUNC_SUBU = 6'b10_0011;
   localparam func_t FUNC_AND  = 6'b10_0100;
   localparam func_t FUNC_OR   = 6'b10_0101;
   localparam func_t FUNC_XOR  = 6'b10_0110;
   localparam func_t FUNC_NOR  = 6'b10_0111;
   localparam func_t FUNC_SLT  = 6'b10_1010;
   localparam func_t FUNC_JR   = 6'b00_1000;
   localparam func_t FUNC_JALR = 6'b00_1001;

   // ALU operations
   localparam alu_op_t ALU_ADD = 4'd0;
   localparam alu_op_t ALU_SUB = 4'd1;
   localparam alu_op_t ALU_AND = 4'd2;
   localparam alu_op_t ALU_OR  = 4'd3;
   localparam alu_op_t ALU_XOR = 4'd4;
   localparam alu_op_t ALU_NOR = 4'd5;
   localparam alu_op_t ALU_SRL = 4'd6;
   localparam alu_op_t ALU_SLL = 4'd7;
   localparam alu_op_t ALU_SRA = 4'd8;
   localparam alu_op_t ALU_SLT = 4'd10;
   localparam alu_op_t ALU_LUI = 4'd11;

   ////////////////////
   // Control groups
   ////////////////////

   typedef struct packed {
      alu_op_t alu_op;
      logic    imm_operand;
      logic    zero_ext;
      logic    use_shamt;
   } ex_ctrl_t;

   typedef struct packed {
      logic      rd_en;
      logic      wr_en;
      logic      unsigned_ld;
      mem_size_t size;
   } mem_ctrl_t;

   // link selects PC+8 as the writeback value
   typedef struct packed {
      reg_addr_t dest;
      logic      reg_we;
      logic      from_alu;
      logic      link;
   } wb_ctrl_t;

   typedef struct packed {
      logic branch;
      logic branch_ne;
      logic jump_rs;
      logic jump_imm;
   } flow_ctrl_t;

endpackage

// ==== verilog/func_decoder.sv ====
`timescale 1ns/1ps

module func_decoder (
   input  decode_pkg::func_t   i_func,
   output decode_pkg::alu_op_t o_alu_op,
   output logic                o_use_shamt,
   output logic                o_link,
   output logic                o_jump_rs
);

   always_comb begin
      o_alu_op    = decode_pkg::ALU_ADD;
      o_use_shamt = 1'b0;
      o_link      = 1'b0;
      o_jump_rs   = 1'b0;

      case (i_func)
         // Shift amount from the instruction
         decode_pkg::FUNC_SLL: begin
            o_alu_op    = decode_pkg::ALU_SLL;
            o_use_shamt = 1'b1;
         end
         decode_pkg::FUNC_SRL: begin
            o_alu_op    = decode_pkg::ALU_SRL;
            o_use_shamt = 1'b1;
         end
         decode_pkg::FUNC_SRA: begin
            o_alu_op    = decode_pkg::ALU_SRA;
            o_use_shamt = 1'b1;
         end
         // Shift amount from rs
         decode_pkg::FUNC_SLLV: o_alu_op = decode_pkg::ALU_SLL;
         decode_pkg::FUNC_SRLV: o_alu_op = decode_pkg::ALU_SRL;
         decode_pkg::FUNC_SRAV: o_alu_op = decode_pkg::ALU_SRA;
         decode_pkg::FUNC_ADDU: o_alu_op = decode_pkg::ALU_ADD;
         decode_pkg::FUNC_SUBU: o_alu_op = decode_pkg::ALU_SUB;
         decode_pkg::FUNC_AND:  o_alu_op = decode_pkg::ALU_AND;
         decode_pkg::FUNC_OR:   o_alu_op = decode_pkg::ALU_OR;
         decode_pkg::FUNC_XOR:  o_alu_op = decode_pkg::ALU_XOR;
         decode_pkg::FUNC_NOR:  o_alu_op = decode_pkg::ALU_NOR;
         decode_pkg::FUNC_SLT:  o_alu_op = decode_pkg::ALU_SLT;
         decode_pkg::FUNC_JR: begin
            o_jump_rs = 1'b1;
         end
         decode_pkg::FUNC_JALR: begin
            o_jump_rs = 1'b1;
            o_link    = 1'b1;
         end
         default: begin
            o_alu_op = decode_pkg::ALU_ADD;
         end
      endcase
   end

endmodule

// ==== verilog/control_decoder.sv ====
`timescale 1ns/1ps

module control_decoder (
   input  decode_pkg::opcode_t    i_opcode,
   input  decode_pkg::func_t      i_func,
   input  decode_pkg::reg_addr_t  i_rt,
   input  decode_pkg::reg_addr_t  i_rd,
   output decode_pkg::ex_ctrl_t   o_ex,
   output decode_pkg::mem_ctrl_t  o_mem,
   output decode_pkg::wb_ctrl_t   o_wb,
   output decode_pkg::flow_ctrl_t o_flow
);

   decode_pkg::alu_op_t func_alu_op;
   logic                func_use_shamt;
   logic                func_link;
   logic                func_jump_rs;

   // Low opcode bits give the access size for loads and stores
   function automatic decode_pkg::mem_size_t access_size(input decode_pkg::opcode_t opcode);
      decode_pkg::mem_size_t size;
      case (opcode[1:0])
         2'b00:   size = decode_pkg::SIZE_BYTE;
         2'b01:   size = decode_pkg::SIZE_HALF;
         default: size = decode_pkg::SIZE_WORD;
      endcase
      return size;
   endfunction

   func_decoder func_decoder_i (
      .i_func      (i_func),
      .o_alu_op    (func_alu_op),
      .o_use_shamt (func_use_shamt),
      .o_link      (func_link),
      .o_jump_rs   (func_jump_rs)
   );

   ////////////////////
   // Main table
   ////////////////////

   always_comb begin
      o_ex   = '0;
      o_mem  = '0;
      o_wb   = '0;
      o_flow = '0;

      case (i_opcode)
         decode_pkg::R_INST: begin
            o_ex.alu_op     = func_alu_op;
            o_ex.use_shamt  = func_use_shamt;
            o_wb.link       = func_link;
            o_flow.jump_rs  = func_jump_rs;
            o_wb.reg_we     = 1'b1;
            o_wb.from_alu   = 1'b1;
         end
         decode_pkg::LB, decode_pkg::LH, decode_pkg::LW,
         decode_pkg::LBU, decode_pkg::LHU, decode_pkg::LWU: begin
            o_ex.imm_operand  = 1'b1;
            o_mem.rd_en       = 1'b1;
            o_mem.size        = access_size(i_opcode);
            o_mem.unsigned_ld = (i_opcode == decode_pkg::LBU) ||
                                (i_opcode == decode_pkg::LHU) ||
                                (i_opcode == decode_pkg::LWU);
            o_wb.reg_we       = 1'b1;
         end
         decode_pkg::SB, decode_pkg::SH, decode_pkg::SW: begin
            o_ex.imm_operand = 1'b1;
            o_mem.wr_en      = 1'b1;
            o_mem.size       = access_size(i_opcode);
         end
         decode_pkg::ADDI, decode_pkg::SLTI: begin
            o_ex.alu_op      = (i_opcode == decode_pkg::SLTI) ? decode_pkg::ALU_SLT
                                                              : decode_pkg::ALU_ADD;
            o_ex.imm_operand = 1'b1;
            o_wb.reg_we      = 1'b1;
            o_wb.from_alu    = 1'b1;
         end
         // Logic immediates are zero extended
         decode_pkg::ANDI, decode_pkg::ORI, decode_pkg::XORI, decode_pkg::LUI: begin
            case (i_opcode)
               decode_pkg::ANDI: o_ex.alu_op = decode_pkg::ALU_AND;
               decode_pkg::ORI:  o_ex.alu_op = decode_pkg::ALU_OR;
               decode_pkg::XORI: o_ex.alu_op = decode_pkg::ALU_XOR;
               default:          o_ex.alu_op = decode_pkg::ALU_LUI;
            endcase
            o_ex.imm_operand = 1'b1;
            o_ex.zero_ext    = 1'b1;
            o_wb.reg_we      = 1'b1;
            o_wb.from_alu    = 1'b1;
         end
         decode_pkg::BEQ, decode_pkg::BNE: begin
            o_ex.imm_operand = 1'b1;
            o_flow.branch    = 1'b1;
            o_flow.branch_ne = (i_opcode == decode_pkg::BNE);
         end
         decode_pkg::J: begin
            o_flow.jump_imm = 1'b1;
         end
         decode_pkg::JAL: begin
            o_flow.jump_imm = 1'b1;
            o_wb.reg_we     = 1'b1;
            o_wb.link       = 1'b1;
         end
         default: begin
            o_flow = '0;
         end
      endcase

      // Linking instructions always target the return address register
      if (o_wb.link) begin
         o_wb.dest = decode_pkg::LINK_REG_ADDR;
      end else if (o_ex.imm_operand) begin
         o_wb.dest = i_rt;
      end else begin
         o_wb.dest = i_rd;
      end
   end

endmodule

// ==== verilog/register_file.sv ====
`timescale 1ns/1ps

module register_file (
   input  logic                  i_clk,
   input  logic                  i_rst,
   input  logic                  i_we,
   input  decode_pkg::reg_addr_t i_wr_addr,
   input  decode_pkg::word_t     i_wr_data,
   input  decode_pkg::reg_addr_t i_rd_addr_a,
   input  decode_pkg::reg_addr_t i_rd_addr_b,
   output decode_pkg::word_t     o_rd_data_a,
   output decode_pkg::word_t     o_rd_data_b
);

   decode_pkg::word_t regs [decode_pkg::NUM_REGS];

   ////////////////////
   // Write port
   ////////////////////

   // Register 0 is an ordinary register here
   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         for (int i = 0; i < decode_pkg::NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (i_we) begin
         regs[i_wr_addr] <= i_wr_data;
      end
   end

   ////////////////////
   // Read ports
   ////////////////////

   // No bypass from a write in the same cycle
   assign o_rd_data_a = regs[i_rd_addr_a];
   assign o_rd_data_b = regs[i_rd_addr_b];

endmodule

// ==== verilog/branch_resolve.sv ====
`timescale 1ns/1ps

module branch_resolve (
   input  logic                   i_clk,
   input  logic                   i_rst,
   input  decode_pkg::flow_ctrl_t i_flow,
   input  decode_pkg::word_t      i_a,
   input  decode_pkg::word_t      i_b,
   output logic                   o_nop
);

   logic equal;
   logic taken;

   assign equal = (i_a == i_b);

   // BNE inverts the compare
   assign taken = i_flow.branch & (i_flow.branch_ne ? ~equal : equal);

   // Flush the instruction fetched behind a redirect
   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         o_nop <= 1'b0;
      end else begin
         o_nop <= i_flow.jump_rs | i_flow.jump_imm | taken;
      end
   end

endmodule

// ==== verilog/instruction_decode.sv ====
`timescale 1ns/1ps

module instruction_decode (
   input  logic                   i_clk,
   input  logic                   i_rst,
   input  decode_pkg::word_t      i_instruction,
   input  decode_pkg::word_t      i_pc,
   input  logic                   i_wb_we,
   input  decode_pkg::reg_addr_t  i_wb_addr,
   input  decode_pkg::word_t      i_wb_data,
   output decode_pkg::ex_ctrl_t   o_ex_ctrl,
   output decode_pkg::mem_ctrl_t  o_mem_ctrl,
   output decode_pkg::wb_ctrl_t   o_wb_ctrl,
   output decode_pkg::word_t      o_pc,
   output decode_pkg::word_t      o_a,
   output decode_pkg::word_t      o_b,
   output decode_pkg::imm_t       o_imm,
   output decode_pkg::shamt_t     o_shamt,
   output logic                   o_branch,
   output logic                   o_jump_rs,
   output logic                   o_jump_imm,
   output decode_pkg::jump_addr_t o_jump_addr,
   output logic                   o_nop
);

   decode_pkg::opcode_t    opcode;
   decode_pkg::func_t      func;
   decode_pkg::reg_addr_t  rs;
   decode_pkg::reg_addr_t  rt;
   decode_pkg::reg_addr_t  rd;
   decode_pkg::imm_t       imm;
   decode_pkg::shamt_t     shamt;
   decode_pkg::jump_addr_t jump_addr;

   decode_pkg::ex_ctrl_t   ex_ctrl;
   decode_pkg::mem_ctrl_t  mem_ctrl;
   decode_pkg::wb_ctrl_t   wb_ctrl;
   decode_pkg::flow_ctrl_t flow_ctrl;
   decode_pkg::word_t      rs_data;
   decode_pkg::word_t      rt_data;

   ////////////////////
   // Field slicing
   ////////////////////

   assign opcode    = i_instruction[decode_pkg::MSB_OPCODE -: $bits(decode_pkg::opcode_t)];
   assign func      = i_instruction[decode_pkg::MSB_FUNC -: $bits(decode_pkg::func_t)];
   assign rs        = i_instruction[decode_pkg::MSB_RS -: $bits(decode_pkg::reg_addr_t)];
   assign rt        = i_instruction[decode_pkg::MSB_RT -: $bits(decode_pkg::reg_addr_t)];
   assign rd        = i_instruction[decode_pkg::MSB_RD -: $bits(decode_pkg::reg_addr_t)];
   assign imm       = i_instruction[decode_pkg::MSB_IMM -: $bits(decode_pkg::imm_t)];
   assign shamt     = i_instruction[decode_pkg::MSB_SHAMT -: $bits(decode_pkg::shamt_t)];
   assign jump_addr = i_instruction[decode_pkg::MSB_JUMP -: $bits(decode_pkg::jump_addr_t)];

   control_decoder control_decoder_i (
      .i_opcode (opcode),
      .i_func   (func),
      .i_rt     (rt),
      .i_rd     (rd),
      .o_ex     (ex_ctrl),
      .o_mem    (mem_ctrl),
      .o_wb     (wb_ctrl),
      .o_flow   (flow_ctrl)
   );

   register_file register_file_i (
      .i_clk       (i_clk),
      .i_rst       (i_rst),
      .i_we        (i_wb_we),
      .i_wr_addr   (i_wb_addr),
      .i_wr_data   (i_wb_data),
      .i_rd_addr_a (rs),
      .i_rd_addr_b (rt),
      .o_rd_data_a (rs_data),
      .o_rd_data_b (rt_data)
   );

   // Compare uses register contents
   branch_resolve branch_resolve_i (
      .i_clk  (i_clk),
      .i_rst  (i_rst),
      .i_flow (flow_ctrl),
      .i_a    (rs_data),
      .i_b    (rt_data),
      .o_nop  (o_nop)
   );

   ////////////////////
   // Output register
   ////////////////////

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         o_ex_ctrl   <= '0;
         o_mem_ctrl  <= '0;
         o_wb_ctrl   <= '0;
         o_pc        <= '0;
         o_a         <= '0;
         o_b         <= '0;
         o_imm       <= '0;
         o_shamt     <= '0;
         o_branch    <= 1'b0;
         o_jump_rs   <= 1'b0;
         o_jump_imm  <= 1'b0;
         o_jump_addr <= '0;
      end else begin
         o_ex_ctrl   <= ex_ctrl;
         o_mem_ctrl  <= mem_ctrl;
         o_wb_ctrl   <= wb_ctrl;
         o_pc        <= i_pc;
         o_a         <= rs_data;
         o_b         <= rt_data;
         o_imm       <= imm;
         o_shamt     <= shamt;
         o_branch    <= flow_ctrl.branch;
         o_jump_rs   <= flow_ctrl.jump_rs;
         o_jump_imm  <= flow_ctrl.jump_imm;
         o_jump_addr <= jump_addr;
      end
   end

endmodule

// ==== tests/decode_model.svh ====
`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

// Everything the DUT presents for one instruction
typedef struct packed {
   decode_pkg::ex_ctrl_t   ex;
   decode_pkg::mem_ctrl_t  mem;
   decode_pkg::wb_ctrl_t   wb;
   decode_pkg::word_t      pc;
   decode_pkg::word_t      a;
   decode_pkg::word_t      b;
   decode_pkg::imm_t       imm;
   decode_pkg::shamt_t     shamt;
   logic                   branch;
   logic                   jump_rs;
   logic                   jump_imm;
   decode_pkg::jump_addr_t jump_addr;
   logic                   nop;
} decode_out_t;

// Register contents seen by the next instruction presented
decode_pkg::word_t reg_model [32];

function automatic decode_pkg::mem_size_t mem_size_of(input decode_pkg::opcode_t op);
   case (op)
      decode_pkg::LB, decode_pkg::LBU, decode_pkg::SB: return decode_pkg::SIZE_BYTE;
      decode_pkg::LH, decode_pkg::LHU, decode_pkg::SH: return decode_pkg::SIZE_HALF;
      default: return decode_pkg::SIZE_WORD;
   endcase
endfunction

function automatic decode_out_t expected_decode(input decode_pkg::word_t instr,
                                                input decode_pkg::word_t pc);
   decode_out_t         e;
   decode_pkg::opcode_t op;
   decode_pkg::func_t   fn;
   e = '0;
   op = instr[31:26];
   fn = instr[5:0];
   e.pc = pc;
   e.a = reg_model[instr[25:21]];
   e.b = reg_model[instr[20:16]];
   e.imm = instr[15:0];
   e.shamt = instr[10:6];
   e.jump_addr = instr[25:0];
   case (op)
      decode_pkg::R_INST: begin
         e.wb.reg_we = 1'b1;
         e.wb.from_alu = 1'b1;
         e.ex.use_shamt = (fn == decode_pkg::FUNC_SLL) || (fn == decode_pkg::FUNC_SRL) ||
                          (fn == decode_pkg::FUNC_SRA);
         e.jump_rs = (fn == decode_pkg::FUNC_JR) || (fn == decode_pkg::FUNC_JALR);
         e.wb.link = (fn == decode_pkg::FUNC_JALR);
         case (fn)
            decode_pkg::FUNC_SLL, decode_pkg::FUNC_SLLV: e.ex.alu_op = decode_pkg::ALU_SLL;
            decode_pkg::FUNC_SRL, decode_pkg::FUNC_SRLV: e.ex.alu_op = decode_pkg::ALU_SRL;
            decode_pkg::FUNC_SRA, decode_pkg::FUNC_SRAV: e.ex.alu_op = decode_pkg::ALU_SRA;
            decode_pkg::FUNC_SUBU: e.ex.alu_op = decode_pkg::ALU_SUB;
            decode_pkg::FUNC_AND:  e.ex.alu_op = decode_pkg::ALU_AND;
            decode_pkg::FUNC_OR:   e.ex.alu_op = decode_pkg::ALU_OR;
            decode_pkg::FUNC_XOR:  e.ex.alu_op = decode_pkg::ALU_XOR;
            decode_pkg::FUNC_NOR:  e.ex.alu_op = decode_pkg::ALU_NOR;
            decode_pkg::FUNC_SLT:  e.ex.alu_op = decode_pkg::ALU_SLT;
            default:               e.ex.alu_op = decode_pkg::ALU_ADD;
         endcase
      end
      decode_pkg::LB, decode_pkg::LH, decode_pkg::LW,
      decode_pkg::LBU, decode_pkg::LHU, decode_pkg::LWU: begin
         e.ex.imm_operand = 1'b1;
         e.mem.rd_en = 1'b1;
         e.mem.size = mem_size_of(op);
         e.mem.unsigned_ld = (op == decode_pkg::LBU) || (op == decode_pkg::LHU) ||
                             (op == decode_pkg::LWU);
         e.wb.reg_we = 1'b1;
      end
      decode_pkg::SB, decode_pkg::SH, decode_pkg::SW: begin
         e.ex.imm_operand = 1'b1;
         e.mem.wr_en = 1'b1;
         e.mem.size = mem_size_of(op);
      end
      decode_pkg::ADDI, decode_pkg::SLTI, decode_pkg::ANDI,
      decode_pkg::ORI, decode_pkg::XORI, decode_pkg::LUI: begin
         e.ex.imm_operand = 1'b1;
         e.ex.zero_ext = !((op == decode_pkg::ADDI) || (op == decode_pkg::SLTI));
         e.wb.reg_we = 1'b1;
         e.wb.from_alu = 1'b1;
         case (op)
            decode_pkg::SLTI: e.ex.alu_op = decode_pkg::ALU_SLT;
            decode_pkg::ANDI: e.ex.alu_op = decode_pkg::ALU_AND;
            decode_pkg::ORI:  e.ex.alu_op = decode_pkg::ALU_OR;
            decode_pkg::XORI: e.ex.alu_op = decode_pkg::ALU_XOR;
            decode_pkg::LUI:  e.ex.alu_op = decode_pkg::ALU_LUI;
            default:          e.ex.alu_op = decode_pkg::ALU_ADD;
         endcase
      end
      decode_pkg::BEQ, decode_pkg::BNE: begin
         e.ex.imm_operand = 1'b1;
         e.branch = 1'b1;
         e.nop = (op == decode_pkg::BEQ) ? (e.a == e.b) : (e.a != e.b);
      end
      decode_pkg::J: begin
         e.jump_imm = 1'b1;
      end
      decode_pkg::JAL: begin
         e.jump_imm = 1'b1;
         e.wb.reg_we = 1'b1;
         e.wb.link = 1'b1;
      end
      default: begin
         e.ex = '0;
      end
   endcase
   e.nop = e.nop | e.jump_rs | e.jump_imm;
   // Return address goes to r31
   if (e.wb.link) begin
      e.wb.dest = 5'd31;
   end else if (e.ex.imm_operand) begin
      e.wb.dest = instr[20:16];
   end else begin
      e.wb.dest = instr[15:11];
   end
   return e;
endfunction

`endif

// ==== tests/tb_instruction_decode.sv ====
`timescale 1ns/1ps

module tb_instruction_decode;

   localparam int CLK_PERIOD      = 40;
   localparam int RESET_CYCLES    = 8;
   localparam int NUM_REGS        = 32;
   localparam int RANDOM_COUNT    = 300;
   // Branch, jump and undefined cases plus the drain
   localparam int DIRECTED_CYCLES = 24;
   localparam int TOTAL_CYCLES    = RESET_CYCLES + 2 * NUM_REGS + RANDOM_COUNT + DIRECTED_CYCLES;
   localparam logic [31:0] SEED   = 32'hfaee_06bb;

   localparam decode_pkg::opcode_t OPCODES [20] = '{
      decode_pkg::R_INST, decode_pkg::LB, decode_pkg::LH, decode_pkg::LW, decode_pkg::LBU,
      decode_pkg::LHU, decode_pkg::LWU, decode_pkg::SB, decode_pkg::SH, decode_pkg::SW,
      decode_pkg::ADDI, decode_pkg::ANDI, decode_pkg::ORI, decode_pkg::XORI, decode_pkg::LUI,
      decode_pkg::SLTI, decode_pkg::BEQ, decode_pkg::BNE, decode_pkg::J, decode_pkg::JAL};
   localparam decode_pkg::func_t FUNCS [15] = '{
      decode_pkg::FUNC_SLL, decode_pkg::FUNC_SRL, decode_pkg::FUNC_SRA, decode_pkg::FUNC_SLLV,
      decode_pkg::FUNC_SRLV, decode_pkg::FUNC_SRAV, decode_pkg::FUNC_ADDU, decode_pkg::FUNC_SUBU,
      decode_pkg::FUNC_AND, decode_pkg::FUNC_OR, decode_pkg::FUNC_XOR, decode_pkg::FUNC_NOR,
      decode_pkg::FUNC_SLT, decode_pkg::FUNC_JR, decode_pkg::FUNC_JALR};

   logic                   i_clk = 1'b0;
   logic                   i_rst;
   decode_pkg::word_t      i_instruction;
   decode_pkg::word_t      i_pc;
   logic                   i_wb_we;
   decode_pkg::reg_addr_t  i_wb_addr;
   decode_pkg::word_t      i_wb_data;
   decode_pkg::ex_ctrl_t   o_ex_ctrl;
   decode_pkg::mem_ctrl_t  o_mem_ctrl;
   decode_pkg::wb_ctrl_t   o_wb_ctrl;
   decode_pkg::word_t      o_pc;
   decode_pkg::word_t      o_a;
   decode_pkg::word_t      o_b;
   decode_pkg::imm_t       o_imm;
   decode_pkg::shamt_t     o_shamt;
   logic                   o_branch;
   logic                   o_jump_rs;
   logic                   o_jump_imm;
   decode_pkg::jump_addr_t o_jump_addr;
   logic                   o_nop;

`include "decode_model.svh"

   decode_pkg::word_t pc_next = 32'h0000_0400;
   int unsigned       neg_count = 0;
   decode_out_t       due_exp;
   decode_out_t       expect_q [$];
   int unsigned       due_q [$];

   instruction_decode instruction_decode_i (
      .i_clk         (i_clk),
      .i_rst         (i_rst),
      .i_instruction (i_instruction),
      .i_pc          (i_pc),
      .i_wb_we       (i_wb_we),
      .i_wb_addr     (i_wb_addr),
      .i_wb_data     (i_wb_data),
      .o_ex_ctrl     (o_ex_ctrl),
      .o_mem_ctrl    (o_mem_ctrl),
      .o_wb_ctrl     (o_wb_ctrl),
      .o_pc          (o_pc),
      .o_a           (o_a),
      .o_b           (o_b),
      .o_imm         (o_imm),
      .o_shamt       (o_shamt),
      .o_branch      (o_branch),
      .o_jump_rs     (o_jump_rs),
      .o_jump_imm    (o_jump_imm),
      .o_jump_addr   (o_jump_addr),
      .o_nop         (o_nop)
   );

   always #(CLK_PERIOD / 2) i_clk = ~i_clk;

   ////////////////////
   // Checking
   ////////////////////

   task automatic fail_run(input string reason);
      $display("%s", reason);
      $display("Something failed");
      $fatal(1);
   endtask

   task automatic check_value(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
      if (actual !== expected) begin
         fail_run($sformatf("mismatch at %0d ns: %s is 0x%0h, expected 0x%0h",
                            $time, name, actual, expected));
      end
   endtask

   task automatic compare_outputs(input decode_out_t exp);
      check_value("o_ex_ctrl", 32'(o_ex_ctrl), 32'(exp.ex));
      check_value("o_mem_ctrl", 32'(o_mem_ctrl), 32'(exp.mem));
      check_value("o_wb_ctrl", 32'(o_wb_ctrl), 32'(exp.wb));
      check_value("o_pc", o_pc, exp.pc);
      check_value("o_a", o_a, exp.a);
      check_value("o_b", o_b, exp.b);
      check_value("o_imm", 32'(o_imm), 32'(exp.imm));
      check_value("o_shamt", 32'(o_shamt), 32'(exp.shamt));
      check_value("o_branch", 32'(o_branch), 32'(exp.branch));
      check_value("o_jump_rs", 32'(o_jump_rs), 32'(exp.jump_rs));
      check_value("o_jump_imm", 32'(o_jump_imm), 32'(exp.jump_imm));
      check_value("o_jump_addr", 32'(o_jump_addr), 32'(exp.jump_addr));
      check_value("o_nop", 32'(o_nop), 32'(exp.nop));
   endtask

   // Outputs are stable at the falling edge
   always @(negedge i_clk) begin
      neg_count = neg_count + 32'd1;
      if (due_q.size() != 0 && due_q[0] == neg_count) begin
         void'(due_q.pop_front());
         due_exp = expect_q.pop_front();
         compare_outputs(due_exp);
      end
   end

   initial begin
      #(CLK_PERIOD * TOTAL_CYCLES * 2);
      fail_run("timeout: the test sequence did not finish in time");
   end

   ////////////////////
   // Stimulus
   ////////////////////

   function automatic decode_pkg::word_t rtype_word(input decode_pkg::reg_addr_t rs,
      input decode_pkg::reg_addr_t rt, input decode_pkg::reg_addr_t rd,
      input decode_pkg::shamt_t shamt, input decode_pkg::func_t fn);
      return {decode_pkg::R_INST, rs, rt, rd, shamt, fn};
   endfunction

   function automatic decode_pkg::word_t itype_word(input decode_pkg::opcode_t op,
      input decode_pkg::reg_addr_t rs, input decode_pkg::reg_addr_t rt,
      input decode_pkg::imm_t imm);
      return {op, rs, rt, imm};
   endfunction

   // Result due two falling edges after the driving edge
   task automatic drive_cycle(input decode_pkg::word_t instr, input logic we,
                              input decode_pkg::reg_addr_t addr, input decode_pkg::word_t data);
      @(posedge i_clk);
      i_instruction <= instr;
      i_pc          <= pc_next;
      i_wb_we       <= we;
      i_wb_addr     <= addr;
      i_wb_data     <= data;
      expect_q.push_back(expected_decode(instr, pc_next));
      due_q.push_back(neg_count + 32'd2);
      if (we) begin
         reg_model[addr] = data;
      end
      pc_next = pc_next + 32'd4;
   endtask

   task automatic issue(input decode_pkg::word_t instr);
      drive_cycle(instr, 1'b0, 5'd0, 32'd0);
   endtask

   task automatic check_reset();
      decode_out_t zero;
      zero = '0;
      for (int n = 0; n < RESET_CYCLES; n++) begin
         @(posedge i_clk);
         if (n == RESET_CYCLES - 1) begin
            i_rst <= 1'b0;
         end
         @(negedge i_clk);
         compare_outputs(zero);
      end
   endtask

   task automatic load_registers();
      decode_pkg::reg_addr_t addr;
      decode_pkg::reg_addr_t other;
      for (int n = 0; n < NUM_REGS; n++) begin
         addr = n[4:0];
         other = addr - 5'd1;
         drive_cycle(rtype_word(other, other, 5'd1, 5'd0, decode_pkg::FUNC_ADDU), 1'b1, addr,
                     $urandom());
      end
      for (int n = 0; n < NUM_REGS; n++) begin
         addr = n[4:0];
         issue(rtype_word(addr, ~addr, 5'd2, 5'd0, decode_pkg::FUNC_ADDU));
      end
   endtask

   task automatic random_stream();
      decode_pkg::word_t body;
      decode_pkg::word_t instr;
      int unsigned       idx;
      for (int n = 0; n < RANDOM_COUNT; n++) begin
         body = $urandom();
         idx = $urandom() % 32'd20;
         instr = {OPCODES[idx[4:0]], body[25:0]};
         if (instr[31:26] == decode_pkg::R_INST) begin
            idx = $urandom() % 32'd15;
            instr[5:0] = FUNCS[idx[3:0]];
         end
         issue(instr);
      end
   endtask

   task automatic branch_cases();
      decode_pkg::word_t rnd;
      rnd = $urandom();
      // r7 becomes a copy of r3
      drive_cycle(rtype_word(5'd1, 5'd2, 5'd10, 5'd0, decode_pkg::FUNC_ADDU), 1'b1, 5'd7,
                  reg_model[5'd3]);
      issue(itype_word(decode_pkg::BEQ, 5'd3, 5'd7, rnd[15:0]));
      issue(itype_word(decode_pkg::BEQ, 5'd3, 5'd4, rnd[31:16]));
      issue(itype_word(decode_pkg::BNE, 5'd3, 5'd7, rnd[23:8]));
      issue(itype_word(decode_pkg::BNE, 5'd3, 5'd4, rnd[15:0]));
      issue(itype_word(decode_pkg::BEQ, 5'd5, 5'd5, rnd[31:16]));
      issue(itype_word(decode_pkg::BNE, 5'd5, 5'd5, rnd[23:8]));
   endtask

   task automatic jump_cases();
      decode_pkg::word_t rnd;
      rnd = $urandom();
      issue({decode_pkg::J, rnd[25:0]});
      issue({decode_pkg::JAL, ~rnd[25:0]});
      issue(rtype_word(5'd9, 5'd0, 5'd12, 5'd0, decode_pkg::FUNC_JR));
      issue(rtype_word(5'd9, 5'd0, 5'd12, 5'd0, decode_pkg::FUNC_JALR));
   endtask

   task automatic undefined_cases();
      issue(itype_word(6'b111111, 5'd1, 5'd2, 16'h0123));
      issue(itype_word(6'b011000, 5'd3, 5'd4, 16'h07ff));
      issue(itype_word(6'b000110, 5'd5, 5'd6, 16'h0000));
      // JR function bits under non-R opcodes
      issue(itype_word(decode_pkg::ADDI, 5'd1, 5'd2, 16'h0008));
      issue(itype_word(6'b111110, 5'd3, 5'd4, 16'h0008));
   endtask

   initial begin
      void'($urandom(SEED));
      i_rst         <= 1'b1;
      i_instruction <= '0;
      i_pc          <= '0;
      i_wb_we       <= 1'b0;
      i_wb_addr     <= '0;
      i_wb_data     <= '0;
      for (int n = 0; n < NUM_REGS; n++) begin
         reg_model[n[4:0]] = '0;
      end
      check_reset();
      load_registers();
      random_stream();
      branch_cases();
      jump_cases();
      undefined_cases();
      while (due_q.size() != 0) begin
         @(negedge i_clk);
      end
      $display("Everything OK");
      $finish;
   end

endmodule

// ==== project.f ====
+incdir+tests
verilog/decode_pkg.sv
verilog/func_decoder.sv
verilog/control_decoder.sv
verilog/register_file.sv
verilog/branch_resolve.sv
verilog/instruction_decode.sv
tests/tb_instruction_decode.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing -f project.f --top-module tb_instruction_decode \
   -o tb_instruction_decode

./obj_dir/tb_instruction_decode
